// ==== design/decodeStage.sv ====
`timescale 1ns/1ns

module decodeStage (
    input  logic               clk,
    input  logic               rst,
    input  mipsPkg::word_t     pcD,
    input  mipsPkg::word_t     instrD,
    output logic               stall,
    output logic               takeJump,
    output mipsPkg::word_t     nextPc,
    hazardIf.decode            hz,
    decodeExecIf.source        de
);

    mipsPkg::opcode_t    opcode;
    mipsPkg::funct_t     funct;
    mipsPkg::regAddr_t   rs;
    mipsPkg::regAddr_t   rt;
    mipsPkg::regAddr_t   rd;
    mipsPkg::word_t      signImm;
    mipsPkg::word_t      zeroImm;
    mipsPkg::word_t      pcPlus4;

    mipsPkg::aluOp_t     aluOp;
    mipsPkg::resultSel_t resultSel;
    mipsPkg::regAddr_t   destReg;
    logic                regWrite;
    logic                memWrite;
    logic                memRead;
    logic                useImm;
    logic                signExt;
    logic                useRs;
    logic                useRt;
    logic                isBeq;
    logic                isBne;
    logic                isJal;
    logic                isJr;

    mipsPkg::word_t      regs [32];
    mipsPkg::word_t      rsFile;
    mipsPkg::word_t      rtFile;
    mipsPkg::word_t      rsVal;
    mipsPkg::word_t      rtVal;
    logic                rsHazard;
    logic                rtHazard;
    logic                branchTaken;

    assign opcode  = mipsPkg::opcode_t'(instrD[31:26]);
    assign funct   = mipsPkg::funct_t'(instrD[5:0]);
    assign rs      = instrD[25:21];
    assign rt      = instrD[20:16];
    assign rd      = instrD[15:11];
    assign signImm = {{16{instrD[15]}}, instrD[15:0]};
    assign zeroImm = {16'b0, instrD[15:0]};
    assign pcPlus4 = pcD + 32'd4;

    // unknown encodings fall through with every control low
    always_comb begin
        aluOp     = mipsPkg::aluAdd;
        resultSel = mipsPkg::resAlu;
        destReg   = rt;
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        memRead   = 1'b0;
        useImm    = 1'b0;
        signExt   = 1'b0;
        useRs     = 1'b0;
        useRt     = 1'b0;
        isBeq     = 1'b0;
        isBne     = 1'b0;
        isJal     = 1'b0;
        isJr      = 1'b0;
        case (opcode)
            mipsPkg::opSpecial: begin
                destReg  = rd;
                regWrite = 1'b1;
                useRs    = 1'b1;
                useRt    = 1'b1;
                case (funct)
                    mipsPkg::fnAddu: aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   aluOp = mipsPkg::aluOr;
                    mipsPkg::fnSlt:  aluOp = mipsPkg::aluSlt;
                    mipsPkg::fnJr: begin
                        regWrite = 1'b0;
                        useRt    = 1'b0;
                        isJr     = 1'b1;
                    end
                    default: begin
                        regWrite = 1'b0;
                        useRs    = 1'b0;
                        useRt    = 1'b0;
                    end
                endcase
            end
            mipsPkg::opOri: begin
                aluOp    = mipsPkg::aluOr;
                regWrite = 1'b1;
                useImm   = 1'b1;
                useRs    = 1'b1;
            end
            mipsPkg::opLui: begin
                aluOp    = mipsPkg::aluLui;
                regWrite = 1'b1;
                useImm   = 1'b1;
            end
            mipsPkg::opLw: begin
                regWrite  = 1'b1;
                memRead   = 1'b1;
                resultSel = mipsPkg::resMem;
                useImm    = 1'b1;
                signExt   = 1'b1;
                useRs     = 1'b1;
            end
            mipsPkg::opSw: begin
                memWrite = 1'b1;
                useImm   = 1'b1;
                signExt  = 1'b1;
                useRs    = 1'b1;
                useRt    = 1'b1;
            end
            mipsPkg::opBeq: begin
                isBeq = 1'b1;
                useRs = 1'b1;
                useRt = 1'b1;
            end
            mipsPkg::opBne: begin
                isBne = 1'b1;
                useRs = 1'b1;
                useRt = 1'b1;
            end
            mipsPkg::opJal: begin
                destReg   = mipsPkg::linkReg;
                regWrite  = 1'b1;
                resultSel = mipsPkg::resLink;
                isJal     = 1'b1;
            end
            default: ;
        endcase
    end

    // register file, written from writeback
    always_ff @(posedge clk) begin
        if (hz.wbWrite) begin
            regs[hz.wbDest] <= hz.wbValue;
        end
    end

    // reads see a write of the same cycle
    assign rsFile = (rs == '0) ? '0 :
                    (hz.wbWrite && hz.wbDest == rs) ? hz.wbValue : regs[rs];
    assign rtFile = (rt == '0) ? '0 :
                    (hz.wbWrite && hz.wbDest == rt) ? hz.wbValue : regs[rt];

    // a load in memory has no value yet, it stalls instead
    assign rsVal = (hz.memWrite && !hz.memIsLoad && hz.memDest == rs) ? hz.memValue : rsFile;
    assign rtVal = (hz.memWrite && !hz.memIsLoad && hz.memDest == rt) ? hz.memValue : rtFile;

    assign rsHazard = useRs && ((hz.execWrite && hz.execDest == rs) ||
                                (hz.memWrite && hz.memIsLoad && hz.memDest == rs));
    assign rtHazard = useRt && ((hz.execWrite && hz.execDest == rt) ||
                                (hz.memWrite && hz.memIsLoad && hz.memDest == rt));
    assign stall    = rsHazard || rtHazard;

    assign branchTaken = (isBeq && rsVal == rtVal) || (isBne && rsVal != rtVal);
    assign takeJump    = !stall && (branchTaken || isJal || isJr);
    assign nextPc      = isJr  ? rsVal :
                         isJal ? {pcPlus4[31:28], instrD[25:0], 2'b00} :
                                 pcPlus4 + {signImm[29:0], 2'b00};

    // decode/execute register, a stall turns it into a bubble
    always_ff @(posedge clk) begin
        if (rst || stall) begin
            de.regWrite <= 1'b0;
            de.memWrite <= 1'b0;
            de.memRead  <= 1'b0;
        end else begin
            // writes to register 0 never leave decode
            de.regWrite <= regWrite && (destReg != '0);
            de.memWrite <= memWrite;
            de.memRead  <= memRead;
        end
    end

    always_ff @(posedge clk) begin
        de.pc        <= pcD;
        de.aluOp     <= aluOp;
        de.srcA      <= rsVal;
        de.srcB      <= useImm ? (signExt ? signImm : zeroImm) : rtVal;
        de.storeData <= rtVal;
        de.destReg   <= destReg;
        de.resultSel <= resultSel;
    end

endmodule

// ==== design/executeStage.sv ====
`timescale 1ns/1ns

module executeStage (
    input logic         clk,
    input logic         rst,
    decodeExecIf.sink   de,
    execMemIf.source    em,
    hazardIf.exec       hz
);

    mipsPkg::word_t aluResult;

    always_comb begin
        case (de.aluOp)
            mipsPkg::aluSub: aluResult = de.srcA - de.srcB;
            mipsPkg::aluAnd: aluResult = de.srcA & de.srcB;
            mipsPkg::aluOr:  aluResult = de.srcA | de.srcB;
            mipsPkg::aluSlt: begin
                aluResult = {{(mipsPkg::dataWidth - 1){1'b0}},
                             ($signed(de.srcA) < $signed(de.srcB))};
            end
            // immediate goes to the upper half
            mipsPkg::aluLui: aluResult = {de.srcB[15:0], 16'b0};
            default:         aluResult = de.srcA + de.srcB;
        endcase
    end

    // any writer here is too young to forward
    assign hz.execDest  = de.destReg;
    assign hz.execWrite = de.regWrite;

    always_ff @(posedge clk) begin
        if (rst) begin
            em.regWrite <= 1'b0;
            em.memWrite <= 1'b0;
            em.memRead  <= 1'b0;
        end else begin
            em.regWrite <= de.regWrite;
            em.memWrite <= de.memWrite;
            em.memRead  <= de.memRead;
        end
    end

    always_ff @(posedge clk) begin
        em.pc        <= de.pc;
        em.aluResult <= aluResult;
        em.storeData <= de.storeData;
        em.destReg   <= de.destReg;
        em.resultSel <= de.resultSel;
    end

endmodule

// ==== design/fetchStage.sv ====
`timescale 1ns/1ns

module fetchStage (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           takeJump,
    input  mipsPkg::word_t nextPc,
    input  mipsPkg::word_t instRdata,
    output mipsPkg::word_t instAddr,
    output mipsPkg::word_t pcD,
    output mipsPkg::word_t instrD
);

    mipsPkg::word_t pc;

    assign instAddr = pc;

    // the delay slot is the instruction fetched while the branch decodes
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= mipsPkg::resetPc;
        end else if (!stall) begin
            if (takeJump) begin
                pc <= nextPc;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    // fetch/decode register, an all-zero word is a nop
    always_ff @(posedge clk) begin
        if (rst) begin
            instrD <= '0;
        end else if (!stall) begin
            instrD <= instRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcD <= pc;
        end
    end

endmodule

// ==== design/memWbStage.sv ====
`timescale 1ns/1ns

module memWbStage (
    input  logic              clk,
    input  logic              rst,
    execMemIf.sink            em,
    hazardIf.mem              hz,
    input  mipsPkg::word_t    dataRdata,
    output mipsPkg::word_t    dataAddr,
    output mipsPkg::word_t    dataWdata,
    output logic              dataWe,
    output logic              grfWe,
    output mipsPkg::regAddr_t grfAddr,
    output mipsPkg::word_t    grfWdata,
    output mipsPkg::word_t    wbPc
);

    mipsPkg::word_t      memValue;
    logic                wbWrite;
    mipsPkg::regAddr_t   wbDest;
    mipsPkg::word_t      wbPcQ;
    mipsPkg::word_t      wbAluValue;
    mipsPkg::word_t      wbLoadData;
    mipsPkg::resultSel_t wbSel;
    mipsPkg::word_t      wbValue;

    // full-word accesses only
    assign dataAddr  = em.aluResult;
    assign dataWdata = em.storeData;
    assign dataWe    = em.memWrite;

    // link value is pc+8, past the delay slot
    assign memValue = (em.resultSel == mipsPkg::resLink) ? em.pc + 32'd8 : em.aluResult;

    assign hz.memDest   = em.destReg;
    assign hz.memWrite  = em.regWrite;
    assign hz.memIsLoad = em.memRead;
    assign hz.memValue  = memValue;

    always_ff @(posedge clk) begin
        if (rst) begin
            wbWrite <= 1'b0;
        end else begin
            wbWrite <= em.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbDest     <= em.destReg;
        wbPcQ      <= em.pc;
        wbAluValue <= memValue;
        wbLoadData <= dataRdata;
        wbSel      <= em.resultSel;
    end

    assign wbValue = (wbSel == mipsPkg::resMem) ? wbLoadData : wbAluValue;

    assign hz.wbDest  = wbDest;
    assign hz.wbWrite = wbWrite;
    assign hz.wbValue = wbValue;

    assign grfWe    = wbWrite;
    assign grfAddr  = wbDest;
    assign grfWdata = wbValue;
    assign wbPc     = wbPcQ;

endmodule

// ==== design/mipsCpu.sv ====
`timescale 1ns/1ns

module mipsCpu (
    input  logic              clk,
    input  logic              rst,
    output mipsPkg::word_t    instAddr,
    input  mipsPkg::word_t    instRdata,
    output mipsPkg::word_t    dataAddr,
    input  mipsPkg::word_t    dataRdata,
    output mipsPkg::word_t    dataWdata,
    output logic              dataWe,
    output logic              grfWe,
    output mipsPkg::regAddr_t grfAddr,
    output mipsPkg::word_t    grfWdata,
    output mipsPkg::word_t    wbPc
);

    logic           stall;
    logic           takeJump;
    mipsPkg::word_t nextPc;
    mipsPkg::word_t pcD;
    mipsPkg::word_t instrD;

    decodeExecIf deBus ();
    execMemIf    emBus ();
    hazardIf     hzBus ();

    fetchStage fetch (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .takeJump  (takeJump),
        .nextPc    (nextPc),
        .instRdata (instRdata),
        .instAddr  (instAddr),
        .pcD       (pcD),
        .instrD    (instrD)
    );

    decodeStage decode (
        .clk      (clk),
        .rst      (rst),
        .pcD      (pcD),
        .instrD   (instrD),
        .stall    (stall),
        .takeJump (takeJump),
        .nextPc   (nextPc),
        .hz       (hzBus.decode),
        .de       (deBus.source)
    );

    executeStage execute (
        .clk (clk),
        .rst (rst),
        .de  (deBus.sink),
        .em  (emBus.source),
        .hz  (hzBus.exec)
    );

    memWbStage memWb (
        .clk       (clk),
        .rst       (rst),
        .em        (emBus.sink),
        .hz        (hzBus.mem),
        .dataRdata (dataRdata),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataWe    (dataWe),
        .grfWe     (grfWe),
        .grfAddr   (grfAddr),
        .grfWdata  (grfWdata),
        .wbPc      (wbPc)
    );

endmodule

// ==== design/mipsPkg.sv ====
package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    typedef logic [dataWidth-1:0]    word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    // boot address of the instruction memory
    localparam word_t    resetPc = 32'h0000_3000;
    localparam regAddr_t linkReg = 5'd31;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opJal     = 6'b000011,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opOri     = 6'b001101,
        opLui     = 6'b001111,
        opLw      = 6'b100011,
        opSw      = 6'b101011
    } opcode_t;

    // function field of special, instr[5:0]
    typedef enum logic [5:0] {
        fnJr   = 6'b001000,
        fnAddu = 6'b100001,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnSlt  = 6'b101010
    } funct_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOp_t;

    // writeback source
    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resLink
    } resultSel_t;

endpackage

// ==== design/pipeIf.sv ====
`timescale 1ns/1ns

// decode to execute register contents
interface decodeExecIf;
    mipsPkg::word_t      pc;
    mipsPkg::aluOp_t     aluOp;
    mipsPkg::word_t      srcA;
    mipsPkg::word_t      srcB;
    mipsPkg::word_t      storeData;
    mipsPkg::regAddr_t   destReg;
    logic                regWrite;
    logic                memWrite;
    logic                memRead;
    mipsPkg::resultSel_t resultSel;

    modport source (output pc, aluOp, srcA, srcB, storeData, destReg,
                    regWrite, memWrite, memRead, resultSel);
    modport sink   (input pc, aluOp, srcA, srcB, storeData, destReg,
                    regWrite, memWrite, memRead, resultSel);
endinterface

// execute to memory register contents
interface execMemIf;
    mipsPkg::word_t      pc;
    mipsPkg::word_t      aluResult;
    mipsPkg::word_t      storeData;
    mipsPkg::regAddr_t   destReg;
    logic                regWrite;
    logic                memWrite;
    logic                memRead;
    mipsPkg::resultSel_t resultSel;

    modport source (output pc, aluResult, storeData, destReg,
                    regWrite, memWrite, memRead, resultSel);
    modport sink   (input pc, aluResult, storeData, destReg,
                    regWrite, memWrite, memRead, resultSel);
endinterface

// later stages report their destinations back to decode
interface hazardIf;
    mipsPkg::regAddr_t execDest;
    logic              execWrite;
    mipsPkg::regAddr_t memDest;
    logic              memWrite;
    logic              memIsLoad;
    mipsPkg::word_t    memValue;
    mipsPkg::regAddr_t wbDest;
    logic              wbWrite;
    mipsPkg::word_t    wbValue;

    modport decode (input execDest, execWrite, memDest, memWrite, memIsLoad,
                    memValue, wbDest, wbWrite, wbValue);
    modport exec   (output execDest, execWrite);
    modport mem    (output memDest, memWrite, memIsLoad, memValue,
                    wbDest, wbWrite, wbValue);
endinterface

// ==== project.f ====
design/mipsPkg.sv
design/pipeIf.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memWbStage.sv
design/mipsCpu.sv
verification/tbMipsCpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tbMipsCpu -f project.f -o simMipsCpu

./obj_dir/simMipsCpu | tee sim.log

grep -q "All tests passed" sim.log

// ==== verification/tbMipsCpu.sv ====
`timescale 1ns/1ns

module tbMipsCpu;

    localparam int progLen = 128;

    logic              clk = 1'b0;
    logic              rst = 1'b1;
    mipsPkg::word_t    instAddr;
    mipsPkg::word_t    instRdata;
    mipsPkg::word_t    instOffset;
    mipsPkg::word_t    dataAddr;
    mipsPkg::word_t    dataRdata;
    mipsPkg::word_t    dataWdata;
    logic              dataWe;
    logic              grfWe;
    mipsPkg::regAddr_t grfAddr;
    mipsPkg::word_t    grfWdata;
    mipsPkg::word_t    wbPc;

    integer            seed;
    mipsPkg::word_t    prog [progLen];
    mipsPkg::word_t    dmem [64];
    bit                noLand [progLen];
    int                jumpPos [$];
    int                jrPos [$];

    // expected events from the reference model, oldest first
    mipsPkg::word_t    expWrAddr [$];
    mipsPkg::word_t    expWrData [$];
    mipsPkg::word_t    expWrPc [$];
    mipsPkg::word_t    expStAddr [$];
    mipsPkg::word_t    expStData [$];

    mipsCpu uut (
        .clk       (clk),
        .rst       (rst),
        .instAddr  (instAddr),
        .instRdata (instRdata),
        .dataAddr  (dataAddr),
        .dataRdata (dataRdata),
        .dataWdata (dataWdata),
        .dataWe    (dataWe),
        .grfWe     (grfWe),
        .grfAddr   (grfAddr),
        .grfWdata  (grfWdata),
        .wbPc      (wbPc)
    );

    always #2 clk = ~clk;

    // fetches past the program read as nop
    assign instOffset = instAddr - mipsPkg::resetPc;
    assign instRdata  = (instOffset < 32'(4 * progLen)) ? prog[instOffset[8:2]] : '0;
    assign dataRdata  = dmem[dataAddr[7:2]];

    always @(posedge clk) begin
        if (dataWe) begin
            dmem[dataAddr[7:2]] <= dataWdata;
        end
    end

    task automatic abortRun();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic reportMismatch(input string name, input mipsPkg::word_t got,
                                  input mipsPkg::word_t expected);
        $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        abortRun();
    endtask

    task automatic reportFailure(input string what);
        $display("Error at %0t ns: %s", $time, what);
        abortRun();
    endtask

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic mipsPkg::word_t rFormat(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [5:0] fn);
        return {6'b0, rs, rt, rd, 5'b0, fn};
    endfunction

    function automatic mipsPkg::word_t iFormat(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // any instruction that does not change control flow
    function automatic mipsPkg::word_t randomPlain();
        logic [4:0]     rs;
        logic [4:0]     rt;
        logic [4:0]     rd;
        logic [15:0]    imm;
        logic [15:0]    off;
        logic [5:0]     fn;
        mipsPkg::word_t w;
        rs  = 5'(pick(8));
        rt  = 5'(pick(8));
        rd  = 5'(pick(8));
        imm = 16'(pick(65536));
        off = 16'(pick(64) * 4);
        case (pick(5))
            0:       fn = mipsPkg::fnAddu;
            1:       fn = mipsPkg::fnSubu;
            2:       fn = mipsPkg::fnAnd;
            3:       fn = mipsPkg::fnOr;
            default: fn = mipsPkg::fnSlt;
        endcase
        case (pick(8))
            4:       w = iFormat(mipsPkg::opOri, rs, rt, imm);
            5:       w = iFormat(mipsPkg::opLui, 5'd0, rt, imm);
            6:       w = iFormat(mipsPkg::opLw, 5'd0, rt, off);
            7:       w = iFormat(mipsPkg::opSw, 5'd0, rt, off);
            default: w = rFormat(rs, rt, rd, fn);
        endcase
        return w;
    endfunction

    // skips the ori and jr of a return sequence
    function automatic int landing(input int start);
        int t;
        t = start;
        while (noLand[7'(t)]) begin
            t++;
        end
        return t;
    endfunction

    task automatic buildProgram();
        int             idx;
        int             k;
        int             n;
        int             pos;
        int             r;
        mipsPkg::word_t target;
        prog = '{default: '0};
        idx  = 0;
        // give r1..r7 a value before anything reads them
        for (k = 1; k < 8; k++) begin
            prog[7'(idx)]     = iFormat(mipsPkg::opLui, 5'd0, 5'(k), 16'(pick(65536)));
            prog[7'(idx + 1)] = iFormat(mipsPkg::opOri, 5'(k), 5'(k), 16'(pick(65536)));
            idx += 2;
        end
        while (idx < progLen - 16) begin
            k = pick(10);
            if (k < 8) begin
                prog[7'(idx)] = randomPlain();
                idx += 1;
            end else if (k == 8) begin
                prog[7'(idx)] = iFormat((pick(2) == 0) ? mipsPkg::opBeq : mipsPkg::opBne,
                                        5'(pick(8)), 5'(pick(8)), 16'd0);
                jumpPos.push_back(idx);
                prog[7'(idx + 1)] = randomPlain();
                idx += 2;
            end else if (pick(2) == 0) begin
                prog[7'(idx)] = {mipsPkg::opJal, 26'd0};
                jumpPos.push_back(idx);
                prog[7'(idx + 1)] = randomPlain();
                idx += 2;
            end else begin
                // lui/ori build the address, jr uses it right away
                r = 1 + pick(7);
                prog[7'(idx)]       = iFormat(mipsPkg::opLui, 5'd0, 5'(r), 16'd0);
                prog[7'(idx + 1)]   = iFormat(mipsPkg::opOri, 5'(r), 5'(r), 16'd0);
                prog[7'(idx + 2)]   = rFormat(5'(r), 5'd0, 5'd0, mipsPkg::fnJr);
                prog[7'(idx + 3)]   = randomPlain();
                noLand[7'(idx + 1)] = 1'b1;
                noLand[7'(idx + 2)] = 1'b1;
                jrPos.push_back(idx);
                idx += 4;
            end
        end
        // all targets point forward, past the delay slot
        for (n = 0; n < jumpPos.size(); n++) begin
            pos = jumpPos[n];
            k   = landing(pos + 2 + pick(6));
            if (prog[7'(pos)][31:26] == mipsPkg::opJal) begin
                target = mipsPkg::resetPc + 32'(4 * k);
                prog[7'(pos)][25:0] = target[27:2];
            end else begin
                prog[7'(pos)][15:0] = 16'(k - pos - 1);
            end
        end
        for (n = 0; n < jrPos.size(); n++) begin
            pos    = jrPos[n];
            target = mipsPkg::resetPc + 32'(4 * landing(pos + 4 + pick(6)));
            prog[7'(pos)][15:0]     = target[31:16];
            prog[7'(pos + 1)][15:0] = target[15:0];
        end
    endtask

    // one instruction at a time, npc carries the delay slot
    task automatic runModel();
        mipsPkg::word_t mreg [32];
        mipsPkg::word_t mmem [64];
        mipsPkg::word_t pc;
        mipsPkg::word_t npc;
        mipsPkg::word_t nnpc;
        mipsPkg::word_t off;
        mipsPkg::word_t ins;
        mipsPkg::word_t a;
        mipsPkg::word_t b;
        mipsPkg::word_t simm;
        mipsPkg::word_t res;
        mipsPkg::word_t addr;
        logic [4:0]     dest;
        logic           wr;
        int             steps;
        mreg  = '{default: '0};
        mmem  = dmem;
        pc    = mipsPkg::resetPc;
        npc   = mipsPkg::resetPc + 32'd4;
        off   = '0;
        steps = 0;
        while (off < 32'(4 * progLen) && steps < 4 * progLen) begin
            ins  = prog[off[8:2]];
            a    = mreg[ins[25:21]];
            b    = mreg[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            addr = a + simm;
            nnpc = npc + 32'd4;
            dest = ins[20:16];
            res  = '0;
            wr   = 1'b0;
            case (ins[31:26])
                mipsPkg::opSpecial: begin
                    dest = ins[15:11];
                    wr   = 1'b1;
                    case (ins[5:0])
                        mipsPkg::fnAddu: res = a + b;
                        mipsPkg::fnSubu: res = a - b;
                        mipsPkg::fnAnd:  res = a & b;
                        mipsPkg::fnOr:   res = a | b;
                        mipsPkg::fnSlt:  res = {31'b0, $signed(a) < $signed(b)};
                        mipsPkg::fnJr: begin
                            wr   = 1'b0;
                            nnpc = a;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                mipsPkg::opOri: begin
                    wr  = 1'b1;
                    res = a | {16'b0, ins[15:0]};
                end
                mipsPkg::opLui: begin
                    wr  = 1'b1;
                    res = {ins[15:0], 16'b0};
                end
                mipsPkg::opLw: begin
                    wr  = 1'b1;
                    res = mmem[addr[7:2]];
                end
                mipsPkg::opSw: begin
                    mmem[addr[7:2]] = b;
                    expStAddr.push_back(addr);
                    expStData.push_back(b);
                end
                mipsPkg::opBeq: begin
                    if (a == b) begin
                        nnpc = npc + {simm[29:0], 2'b00};
                    end
                end
                mipsPkg::opBne: begin
                    if (a != b) begin
                        nnpc = npc + {simm[29:0], 2'b00};
                    end
                end
                mipsPkg::opJal: begin
                    wr   = 1'b1;
                    dest = 5'd31;
                    res  = pc + 32'd8;
                    nnpc = {npc[31:28], ins[25:0], 2'b00};
                end
                default: ;
            endcase
            if (wr && dest != 5'd0) begin
                mreg[dest] = res;
                expWrAddr.push_back({27'b0, dest});
                expWrData.push_back(res);
                expWrPc.push_back(pc);
            end
            pc  = npc;
            npc = nnpc;
            off = pc - mipsPkg::resetPc;
            steps++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst && grfWe) begin
            if (expWrAddr.size() == 0) begin
                reportFailure("register write after the model ran out of writes");
            end else begin
                assert ({27'b0, grfAddr} == expWrAddr[0])
                    else reportMismatch("grfAddr", {27'b0, grfAddr}, expWrAddr[0]);
                assert (grfWdata == expWrData[0])
                    else reportMismatch("grfWdata", grfWdata, expWrData[0]);
                // tracks where branches and jumps went
                assert (wbPc == expWrPc[0])
                    else reportMismatch("wbPc", wbPc, expWrPc[0]);
                void'(expWrAddr.pop_front());
                void'(expWrData.pop_front());
                void'(expWrPc.pop_front());
            end
        end
        if (!rst && dataWe) begin
            if (expStAddr.size() == 0) begin
                reportFailure("store after the model ran out of stores");
            end else begin
                assert (dataAddr == expStAddr[0])
                    else reportMismatch("dataAddr", dataAddr, expStAddr[0]);
                assert (dataWdata == expStData[0])
                    else reportMismatch("dataWdata", dataWdata, expStData[0]);
                void'(expStAddr.pop_front());
                void'(expStData.pop_front());
            end
        end
    end

    initial begin
        int i;
        seed = 32'had6993f0;
        for (i = 0; i < 64; i++) begin
            dmem[6'(i)] = 32'h5a00_0000 ^ (32'(i) * 32'h0001_0203);
        end
        buildProgram();
        runModel();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (instAddr == mipsPkg::resetPc)
            else reportMismatch("instAddr", instAddr, mipsPkg::resetPc);
        assert (!grfWe) else reportMismatch("grfWe", {31'b0, grfWe}, 32'd0);
        assert (!dataWe) else reportMismatch("dataWe", {31'b0, dataWe}, 32'd0);
        while (expWrAddr.size() != 0 || expStAddr.size() != 0) begin
            @(posedge clk);
        end
        // trailing nops drain, a stray write still trips the checker
        repeat (12) @(posedge clk);
        $display("All tests passed");
        $finish;
    end

    initial begin
        #(4 * progLen * 4 + 200);
        $display("Timeout: the DUT did not retire the whole program in time");
        abortRun();
    end

endmodule
